/* source/vid_config.svh */
`ifndef VID_CONFIG_SVH
`define VID_CONFIG_SVH

// Visible screen size.
`define VID_LINE_PIXELS    160
`define VID_VISIBLE_LINES  144

// Line timing in dots.
`define VID_TOTAL_LINES    154
`define VID_LINE_CYCLES    456
`define VID_OAM_CYCLES     80

// Memory sizes in bytes.
`define VID_VRAM_DEPTH     8192
`define VID_OAM_DEPTH      160

`endif

/* source/vid_pkg.sv */
`default_nettype none

package vid_pkg;

	// One host or register access.
	typedef struct packed {
		logic [15:0] adr;
		logic [7:0]  wdata;
		logic        rd;
		logic        wr;
	} bus_req_t;

	// One access on a memory port.
	typedef struct packed {
		logic [12:0] adr;
		logic [7:0]  wdata;
		logic        rd;
		logic        wr;
	} mem_req_t;

	typedef struct packed {
		logic [1:0] shade;
		logic [7:0] x;
		logic [7:0] y;
	} pixel_t;

	typedef enum logic [2:0] {
		region_none,
		region_vram,
		region_oam,
		region_ppu_reg
	} vid_region_e;

	// Encoded as the STAT mode bits.
	typedef enum logic [1:0] {
		mode_hblank   = 2'd0,
		mode_vblank   = 2'd1,
		mode_oam_scan = 2'd2,
		mode_transfer = 2'd3
	} ppu_mode_e;

endpackage

`default_nettype wire

/* source/vid_memmap.sv */
`timescale 1ns/10ps
`default_nettype none

module vid_memmap (
	input  wire [15:0]          adr,
	output vid_pkg::vid_region_e region
);

	import vid_pkg::*;

	always_comb begin
		region = region_none;
		if (adr[15:13] == 3'b100) begin
			region = region_vram; // 8000 to 9FFF.
		end else if ((adr[15:8] == 8'hfe) && (adr[7:0] < 8'ha0)) begin
			region = region_oam;
		end else if (adr[15:4] == 12'hff4) begin
			region = region_ppu_reg;
		end
	end

endmodule

`default_nettype wire

/* source/vid_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vid_config.svh"

module vid_ram #(
	parameter int DEPTH = `VID_VRAM_DEPTH,
	parameter int ADR_W = $clog2(DEPTH)
) (
	input  wire                    gbclk,
	input  wire                    rst_n,
	input  wire vid_pkg::mem_req_t req,
	output logic [7:0]             rdata
);

	logic [7:0]       mem [DEPTH];
	logic [ADR_W-1:0] adr;

	assign adr = req.adr[ADR_W-1:0];

	always_ff @(posedge gbclk) begin
		if (req.wr) begin
			mem[adr] <= req.wdata;
		end
		if (req.rd) begin
			rdata <= mem[adr]; // Holds until the next read.
		end
	end

	// The arbiter steers one access per cycle to this port.
	a_single_access: assert property (@(posedge gbclk) disable iff (!rst_n)
		!(req.rd && req.wr));

endmodule

`default_nettype wire

/* source/vid_bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module vid_bus_arbiter (
	input  wire                    gbclk,
	input  wire                    rst_n,
	input  wire vid_pkg::bus_req_t host_req,
	output logic [7:0]             host_rdata,
	output logic                   host_rvalid,
	input  wire vid_pkg::ppu_mode_e mode,
	input  wire vid_pkg::mem_req_t ppu_vram_req,
	output vid_pkg::mem_req_t      vram_req,
	input  wire [7:0]              vram_rdata,
	output vid_pkg::mem_req_t      oam_req,
	input  wire [7:0]              oam_rdata,
	output vid_pkg::bus_req_t      reg_req,
	input  wire [7:0]              reg_rdata
);

	import vid_pkg::*;

	vid_region_e region;
	vid_region_e rd_src;
	logic        vram_lock;
	logic        oam_lock;
	logic        host_vram;
	logic        host_oam;
	logic        locked;

	vid_memmap map0 (
		.adr   (host_req.adr),
		.region(region)
	);

	assign vram_lock = (mode == mode_transfer);
	assign oam_lock  = (mode == mode_transfer) || (mode == mode_oam_scan);
	assign host_vram = (region == region_vram) && !vram_lock;
	assign host_oam  = (region == region_oam) && !oam_lock;
	assign locked    = ((region == region_vram) && vram_lock) ||
	                   ((region == region_oam) && oam_lock);

	always_comb begin
		vram_req = '0;
		if (vram_lock) begin
			vram_req = ppu_vram_req;
		end else if (host_vram) begin
			vram_req.adr   = host_req.adr[12:0];
			vram_req.wdata = host_req.wdata;
			vram_req.rd    = host_req.rd;
			vram_req.wr    = host_req.wr;
		end
	end

	always_comb begin
		oam_req = '0;
		if (host_oam) begin
			oam_req.adr   = {5'd0, host_req.adr[7:0]};
			oam_req.wdata = host_req.wdata;
			oam_req.rd    = host_req.rd;
			oam_req.wr    = host_req.wr;
		end
	end

	assign reg_req = (region == region_ppu_reg) ? host_req : '0;

	// Locked reads return FF like unmapped ones.
	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n) begin
			host_rvalid <= 1'b0;
			rd_src      <= region_none;
		end else begin
			host_rvalid <= host_req.rd;
			if (host_req.rd) begin
				rd_src <= locked ? region_none : region;
			end
		end
	end

	always_comb begin
		case (rd_src)
			region_vram:    host_rdata = vram_rdata;
			region_oam:     host_rdata = oam_rdata;
			region_ppu_reg: host_rdata = reg_rdata;
			default:        host_rdata = 8'hff;
		endcase
	end

	// The PPU never writes, so a locked port sees no write at all.
	a_vram_lock: assert property (@(posedge gbclk) disable iff (!rst_n)
		vram_lock |-> !vram_req.wr);

endmodule

`default_nettype wire

/* source/vid_ppu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vid_config.svh"

module vid_ppu (
	input  wire                    gbclk,
	input  wire                    rst_n,
	input  wire vid_pkg::bus_req_t reg_req,
	output logic [7:0]             reg_rdata,
	output vid_pkg::ppu_mode_e     mode,
	output vid_pkg::mem_req_t      vram_req,
	input  wire [7:0]              vram_rdata,
	output vid_pkg::pixel_t        pix,
	output logic                   pix_valid,
	input  wire                    pix_ready,
	output logic                   irq_vblank,
	output logic                   irq_stat
);

	import vid_pkg::*;

	localparam logic [9:0] LAST_DOT     = 10'(`VID_LINE_CYCLES - 1);
	localparam logic [9:0] OAM_LAST     = 10'(`VID_OAM_CYCLES - 1);
	localparam logic [7:0] LAST_LINE    = 8'(`VID_TOTAL_LINES - 1);
	localparam logic [7:0] FIRST_VBLANK = 8'(`VID_VISIBLE_LINES);
	localparam logic [7:0] LINE_PIXELS  = 8'(`VID_LINE_PIXELS);
	localparam logic [7:0] LAST_X       = 8'(`VID_LINE_PIXELS - 1);

	typedef enum logic [2:0] {
		fetch_idle,
		fetch_map,
		fetch_lo,
		fetch_hi,
		fetch_wait,
		fetch_full
	} fetch_state_e;

	logic [7:0]   lcdc;
	logic [3:0]   stat_ie;
	logic [7:0]   scy;
	logic [7:0]   scx;
	logic [7:0]   lyc;
	logic [7:0]   bgp;
	logic [7:0]   ly;
	logic [7:0]   ly_next;
	logic [9:0]   dot;
	logic         disp_q;
	logic         line_end;
	logic         line_done;
	logic         xfer_start;
	fetch_state_e fstate;
	logic [4:0]   fetch_col;
	logic [4:0]   map_col;
	logic [7:0]   bg_y;
	logic [12:0]  tile_adr;
	logic [7:0]   fetch_lo_q;
	logic [7:0]   fetch_hi_q;
	logic [7:0]   sh_lo;
	logic [7:0]   sh_hi;
	logic [3:0]   sh_cnt;
	logic [2:0]   skip;
	logic [7:0]   out_x;
	logic         out_free;
	logic         sh_shift;
	logic         sh_emit;
	logic         sh_load;

	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n) begin
			lcdc    <= 8'h00;
			stat_ie <= 4'h0;
			scy     <= 8'h00;
			scx     <= 8'h00;
			lyc     <= 8'h00;
			bgp     <= 8'hfc;
		end else if (reg_req.wr) begin
			case (reg_req.adr[3:0])
				4'h0: lcdc    <= reg_req.wdata;
				4'h1: stat_ie <= reg_req.wdata[6:3];
				4'h2: scy     <= reg_req.wdata;
				4'h3: scx     <= reg_req.wdata;
				4'h5: lyc     <= reg_req.wdata;
				4'h7: bgp     <= reg_req.wdata;
				default: ; // LY is read only.
			endcase
		end
	end

	always_ff @(posedge gbclk) begin
		if (reg_req.rd) begin
			case (reg_req.adr[3:0])
				4'h0:    reg_rdata <= lcdc;
				4'h1:    reg_rdata <= {1'b1, stat_ie, (ly == lyc), mode};
				4'h2:    reg_rdata <= scy;
				4'h3:    reg_rdata <= scx;
				4'h4:    reg_rdata <= ly;
				4'h5:    reg_rdata <= lyc;
				4'h7:    reg_rdata <= bgp;
				default: reg_rdata <= 8'hff;
			endcase
		end
	end

	assign line_end   = ((mode == mode_hblank) && (dot >= LAST_DOT)) ||
	                    ((mode == mode_vblank) && (dot == LAST_DOT));
	assign ly_next    = (ly == LAST_LINE) ? 8'd0 : ly + 8'd1;
	assign xfer_start = lcdc[7] && disp_q && (mode == mode_oam_scan) && (dot == OAM_LAST);
	assign line_done  = pix_valid && pix_ready && (pix.x == LAST_X);

	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n) begin
			disp_q     <= 1'b0;
			mode       <= mode_hblank;
			dot        <= '0;
			ly         <= '0;
			irq_vblank <= 1'b0;
			irq_stat   <= 1'b0;
		end else begin
			disp_q     <= lcdc[7];
			irq_vblank <= 1'b0;
			irq_stat   <= 1'b0;
			if (!lcdc[7]) begin
				mode <= mode_hblank;
				dot  <= '0;
				ly   <= '0;
			end else if (!disp_q) begin
				mode <= mode_oam_scan; // First line after enable.
				dot  <= '0;
			end else if (line_end) begin
				dot      <= '0;
				ly       <= ly_next;
				irq_stat <= stat_ie[3] && (ly_next == lyc);
				if (ly_next == FIRST_VBLANK) begin
					mode       <= mode_vblank;
					irq_vblank <= 1'b1;
				end else if (ly_next < FIRST_VBLANK) begin
					mode <= mode_oam_scan;
				end
			end else begin
				if (dot != '1) begin
					dot <= dot + 10'd1; // Saturates on a long transfer.
				end
				if (xfer_start) begin
					mode <= mode_transfer;
				end else if (line_done) begin
					mode <= mode_hblank;
				end
			end
		end
	end

	assign bg_y    = ly + scy;
	assign map_col = fetch_col + scx[7:3];

	always_comb begin
		vram_req = '0;
		case (fstate)
			fetch_map: begin
				vram_req.adr = {2'b11, lcdc[3], bg_y[7:3], map_col};
				vram_req.rd  = 1'b1;
			end
			fetch_lo: begin
				vram_req.adr = {1'b0, vram_rdata, bg_y[2:0], 1'b0}; // Map byte is on rdata.
				vram_req.rd  = 1'b1;
			end
			fetch_hi: begin
				vram_req.adr = tile_adr | 13'd1;
				vram_req.rd  = 1'b1;
			end
			default: ;
		endcase
	end

	assign out_free = !pix_valid || pix_ready;
	assign sh_shift = (sh_cnt != 4'd0) && ((skip != 3'd0) || (out_free && (out_x != LINE_PIXELS)));
	assign sh_emit  = sh_shift && (skip == 3'd0);
	assign sh_load  = (fstate == fetch_full) &&
	                  ((sh_cnt == 4'd0) || ((sh_cnt == 4'd1) && sh_shift));

	always_ff @(posedge gbclk or negedge rst_n) begin
		if (!rst_n) begin
			fstate    <= fetch_idle;
			fetch_col <= '0;
			sh_cnt    <= '0;
			skip      <= '0;
			out_x     <= '0;
			pix_valid <= 1'b0;
		end else if (xfer_start) begin
			fstate    <= fetch_map;
			fetch_col <= '0;
			sh_cnt    <= '0;
			skip      <= scx[2:0]; // Fine scroll drops the first pixels.
			out_x     <= '0;
			pix_valid <= 1'b0;
		end else if (mode != mode_transfer) begin
			fstate    <= fetch_idle;
			sh_cnt    <= '0;
			pix_valid <= 1'b0;
		end else begin
			case (fstate)
				fetch_map: begin
					fetch_col <= fetch_col + 5'd1;
					fstate    <= fetch_lo;
				end
				fetch_lo:   fstate <= fetch_hi;
				fetch_hi:   fstate <= fetch_wait;
				fetch_wait: fstate <= fetch_full;
				fetch_full: begin
					if (sh_load) begin
						fstate <= fetch_map;
					end
				end
				default: fstate <= fetch_idle;
			endcase
			if (sh_load) begin
				sh_cnt <= 4'd8;
			end else if (sh_shift) begin
				sh_cnt <= sh_cnt - 4'd1;
			end
			if (sh_shift && (skip != 3'd0)) begin
				skip <= skip - 3'd1;
			end
			if (sh_emit) begin
				pix_valid <= 1'b1;
				out_x     <= out_x + 8'd1;
			end else if (out_free) begin
				pix_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge gbclk) begin
		if (fstate == fetch_lo) begin
			tile_adr <= {1'b0, vram_rdata, bg_y[2:0], 1'b0};
		end
		if (fstate == fetch_hi) begin
			fetch_lo_q <= vram_rdata;
		end
		if (fstate == fetch_wait) begin
			fetch_hi_q <= vram_rdata;
		end
		if (sh_load) begin
			sh_lo <= fetch_lo_q;
			sh_hi <= fetch_hi_q;
		end else if (sh_shift) begin
			sh_lo <= {sh_lo[6:0], 1'b0};
			sh_hi <= {sh_hi[6:0], 1'b0};
		end
		if (sh_emit) begin
			pix.shade <= bgp[{sh_hi[7], sh_lo[7], 1'b0} +: 2]; // BGP field of the colour.
			pix.x     <= out_x;
			pix.y     <= ly;
		end
	end

	a_pix_hold: assert property (@(posedge gbclk) disable iff (!rst_n || !lcdc[7])
		(pix_valid && !pix_ready) |=> (pix_valid && $stable(pix)));

	a_no_vblank_xfer: assert property (@(posedge gbclk) disable iff (!rst_n)
		(ly >= FIRST_VBLANK) |-> (mode != mode_transfer));

endmodule

`default_nettype wire

/* source/vid_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vid_config.svh"

module vid_top (
	input  wire                    gbclk,
	input  wire                    rst_n,
	input  wire vid_pkg::bus_req_t host_req,
	output logic [7:0]             host_rdata,
	output logic                   host_rvalid,
	output vid_pkg::pixel_t        pix,
	output logic                   pix_valid,
	input  wire                    pix_ready,
	output logic                   irq_vblank,
	output logic                   irq_stat
);

	import vid_pkg::*;

	ppu_mode_e mode;
	mem_req_t  ppu_vram_req;
	mem_req_t  vram_req;
	mem_req_t  oam_req;
	bus_req_t  reg_req;
	logic [7:0] vram_rdata;
	logic [7:0] oam_rdata;
	logic [7:0] reg_rdata;

	vid_bus_arbiter arb0 (
		.gbclk       (gbclk),
		.rst_n       (rst_n),
		.host_req    (host_req),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.mode        (mode),
		.ppu_vram_req(ppu_vram_req),
		.vram_req    (vram_req),
		.vram_rdata  (vram_rdata),
		.oam_req     (oam_req),
		.oam_rdata   (oam_rdata),
		.reg_req     (reg_req),
		.reg_rdata   (reg_rdata)
	);

	vid_ram #(.DEPTH(`VID_VRAM_DEPTH)) vram0 (
		.gbclk(gbclk),
		.rst_n(rst_n),
		.req  (vram_req),
		.rdata(vram_rdata)
	);

	vid_ram #(.DEPTH(`VID_OAM_DEPTH)) oam0 (
		.gbclk(gbclk),
		.rst_n(rst_n),
		.req  (oam_req),
		.rdata(oam_rdata)
	);

	vid_ppu ppu0 (
		.gbclk     (gbclk),
		.rst_n     (rst_n),
		.reg_req   (reg_req),
		.reg_rdata (reg_rdata),
		.mode      (mode),
		.vram_req  (ppu_vram_req),
		.vram_rdata(vram_rdata),
		.pix       (pix),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.irq_vblank(irq_vblank),
		.irq_stat  (irq_stat)
	);

endmodule

`default_nettype wire

/* verif/vid_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vid_config.svh"

module vid_tb;

	import vid_pkg::*;

	localparam int FRAME_CYCLES = `VID_TOTAL_LINES * `VID_LINE_CYCLES;
	localparam int LINE_LIMIT   = 4 * `VID_LINE_CYCLES;
	localparam int NPIX         = 2 * `VID_LINE_PIXELS; // Lines 0 and 1.
	localparam int IRQ_NONE     = 0;
	localparam int IRQ_STAT     = 1;
	localparam int IRQ_VBLANK   = 2;

	logic       gbclk;
	logic       rst_n;
	bus_req_t   host_req;
	logic [7:0] host_rdata;
	logic       host_rvalid;
	pixel_t     pix;
	logic       pix_valid;
	logic       pix_ready;
	logic       irq_vblank;
	logic       irq_stat;
	logic [7:0] vram_model [`VID_VRAM_DEPTH];
	logic [7:0] oam_model [`VID_OAM_DEPTH];
	int         errors = 0;
	int         checks = 0;

	vid_top dut0 (
		.gbclk      (gbclk),
		.rst_n      (rst_n),
		.host_req   (host_req),
		.host_rdata (host_rdata),
		.host_rvalid(host_rvalid),
		.pix        (pix),
		.pix_valid  (pix_valid),
		.pix_ready  (pix_ready),
		.irq_vblank (irq_vblank),
		.irq_stat   (irq_stat)
	);

	initial gbclk = 1'b0;
	always #4 gbclk = ~gbclk;

	// Two frames of interrupt test, setup traffic and margin.
	initial begin
		#(8 * (3 * FRAME_CYCLES + 20000));
		$display("timeout: the tests did not finish within three frames");
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected shade %0d x %0d y %0d, actual shade %0d x %0d y %0d",
				name, exp.shade, exp.x, exp.y, act.shade, act.x, act.y);
		end
	endtask

	task automatic check_mode(input string name, input ppu_mode_e exp, input ppu_mode_e act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %s, actual %s", name, exp.name(), act.name());
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic host_write(input logic [15:0] adr, input logic [7:0] data);
		@(negedge gbclk);
		host_req = '{adr: adr, wdata: data, rd: 1'b0, wr: 1'b1};
		@(negedge gbclk);
		host_req = '0;
	endtask

	task automatic host_read(input logic [15:0] adr, output logic [7:0] data);
		@(negedge gbclk);
		host_req = '{adr: adr, wdata: 8'h00, rd: 1'b1, wr: 1'b0};
		@(negedge gbclk);
		host_req = '0;
		if (!host_rvalid) begin
			errors++;
			$display("read of %h returned no data one cycle after the request", adr);
		end
		data = host_rdata;
	endtask

	task automatic expect_read(input string name, input logic [15:0] adr, input logic [7:0] exp);
		logic [7:0] d;
		host_read(adr, d);
		check_byte(name, exp, d);
	endtask

	task automatic vram_write(input logic [12:0] adr, input logic [7:0] data);
		host_write({3'b100, adr}, data);
		vram_model[adr] = data;
	endtask

	function automatic logic [7:0] fill_byte(input logic [12:0] adr);
		logic [12:0] mix;
		mix = (adr * 13'd29) ^ (adr >> 5);
		return mix[7:0];
	endfunction

	// Background fetch and shade rule for pixel idx of lines 0 and 1.
	function automatic pixel_t expect_pixel(input int idx, input logic [7:0] lcdc,
		input logic [7:0] scy, input logic [7:0] scx, input logic [7:0] bgp);
		pixel_t      p;
		logic [7:0]  bx;
		logic [7:0]  by;
		logic [7:0]  tile;
		logic [12:0] map_adr;
		logic [12:0] row_adr;
		logic [1:0]  c;
		p.x     = 8'(idx % `VID_LINE_PIXELS);
		p.y     = 8'(idx / `VID_LINE_PIXELS);
		bx      = p.x + scx;
		by      = p.y + scy;
		map_adr = (lcdc[3] ? 13'h1c00 : 13'h1800) + {3'd0, by[7:3], 5'd0} + {8'd0, bx[7:3]};
		tile    = vram_model[map_adr];
		row_adr = {1'b0, tile, 4'd0} + {9'd0, by[2:0], 1'b0};
		c       = {vram_model[row_adr + 13'd1][3'd7 - bx[2:0]],
		           vram_model[row_adr][3'd7 - bx[2:0]]};
		p.shade = 2'(bgp >> (2 * c));
		return p;
	endfunction

	task automatic register_test();
		logic [7:0] d;
		check_byte("reset_outputs", 8'h00, {4'h0, host_rvalid, pix_valid, irq_vblank, irq_stat});
		expect_read("reset_lcdc", 16'hff40, 8'h00);
		expect_read("reset_scy", 16'hff42, 8'h00);
		expect_read("reset_scx", 16'hff43, 8'h00);
		expect_read("reset_lyc", 16'hff45, 8'h00);
		expect_read("reset_bgp", 16'hff47, 8'hfc);
		host_write(16'hff40, 8'h08);
		host_write(16'hff42, 8'h5a);
		host_write(16'hff43, 8'ha5);
		host_write(16'hff45, 8'h3c);
		host_write(16'hff47, 8'he4);
		host_write(16'hff41, 8'h40);
		host_write(16'hff40, 8'h88); // LY counts only with the display on.
		host_write(16'hff44, 8'h55);
		expect_read("ly_read_only", 16'hff44, 8'h00);
		host_write(16'hff40, 8'h08);
		expect_read("rw_lcdc", 16'hff40, 8'h08);
		expect_read("rw_scy", 16'hff42, 8'h5a);
		expect_read("rw_scx", 16'hff43, 8'ha5);
		expect_read("rw_lyc", 16'hff45, 8'h3c);
		expect_read("rw_bgp", 16'hff47, 8'he4);
		host_read(16'hff41, d);
		check_byte("rw_stat", 8'h40, d & 8'h47); // Enable bit 6, no match, hblank.
		expect_read("ppu_unmapped_6", 16'hff46, 8'hff);
		expect_read("ppu_unmapped_f", 16'hff4f, 8'hff);
		expect_read("none_low", 16'h0000, 8'hff);
		expect_read("none_oam_end", 16'hfea0, 8'hff);
		expect_read("none_high", 16'hff80, 8'hff);
		host_write(16'hff40, 8'h00);
		host_write(16'hff41, 8'h00);
	endtask

	task automatic memory_test();
		logic [12:0] adr [16];
		for (int i = 0; i < 16; i++) begin
			adr[i] = 13'($urandom);
			vram_write(adr[i], 8'($urandom));
		end
		for (int i = 0; i < 16; i++) begin
			expect_read("vram_readback", {3'b100, adr[i]}, vram_model[adr[i]]);
		end
		for (int i = 0; i < `VID_OAM_DEPTH; i++) begin
			oam_model[i] = 8'($urandom);
			host_write({8'hfe, 8'(i)}, oam_model[i]);
		end
		for (int i = 0; i < `VID_OAM_DEPTH; i++) begin
			expect_read("oam_readback", {8'hfe, 8'(i)}, oam_model[i]);
		end
	endtask

	task automatic fill_vram();
		for (int a = 0; a < 13'h1000; a++) begin
			vram_write(13'(a), fill_byte(13'(a))); // Tile data.
		end
		for (int a = 13'h1800; a < 13'h2000; a++) begin
			vram_write(13'(a), fill_byte(13'(a))); // Both maps.
		end
	endtask

	task automatic bg_test(input string name, input logic [7:0] lcdc, input logic [7:0] scy,
		input logic [7:0] scx, input logic [7:0] bgp, input bit stall);
		pixel_t got [$];
		int     cycles;
		host_write(16'hff42, scy);
		host_write(16'hff43, scx);
		host_write(16'hff47, bgp);
		host_write(16'hff40, lcdc);
		cycles = 0;
		while ((got.size() < NPIX) && (cycles < 2 * LINE_LIMIT)) begin
			@(negedge gbclk);
			pix_ready = stall ? 1'($urandom) : 1'b1;
			if (pix_valid && pix_ready) begin
				got.push_back(pix); // Accepted at the coming edge.
			end
			cycles++;
		end
		pix_ready = 1'b1;
		host_write(16'hff40, 8'h00);
		if (got.size() < NPIX) begin
			errors++;
			$display("%s: pixel stream stalled after %0d pixels", name, got.size());
		end
		foreach (got[i]) begin
			check_pixel(name, expect_pixel(i, lcdc, scy, scx, bgp), got[i]);
		end
	endtask

	task automatic wait_mode(input ppu_mode_e m);
		logic [7:0] d;
		int         polls;
		polls = 0;
		do begin
			host_read(16'hff41, d);
			polls++;
		end while ((ppu_mode_e'(d[1:0]) != m) && (polls < LINE_LIMIT));
		if (ppu_mode_e'(d[1:0]) != m) begin
			errors++;
			$display("STAT never showed mode %s", m.name());
		end
	endtask

	task automatic lock_test();
		logic [7:0] d;
		host_write(16'hff40, 8'h80);
		wait_mode(mode_transfer);
		expect_read("lock_vram_read", 16'h9f00, 8'hff);
		host_write(16'h9f00, ~vram_model[13'h1f00]);
		host_read(16'hff41, d);
		check_mode("lock_vram_mode", mode_transfer, ppu_mode_e'(d[1:0]));
		host_write(16'hff40, 8'h00);
		expect_read("lock_vram_kept", 16'h9f00, vram_model[13'h1f00]);
		host_write(16'hff40, 8'h80);
		wait_mode(mode_oam_scan);
		expect_read("lock_oam_read", 16'hfe10, 8'hff);
		host_write(16'hfe10, ~oam_model[8'h10]);
		host_read(16'hff41, d);
		check_mode("lock_oam_mode", mode_oam_scan, ppu_mode_e'(d[1:0]));
		host_write(16'hff40, 8'h00);
		expect_read("lock_oam_kept", 16'hfe10, oam_model[8'h10]);
	endtask

	task automatic wait_irq(output int kind);
		int cycles;
		kind   = IRQ_NONE;
		cycles = 0;
		while ((kind == IRQ_NONE) && (cycles < FRAME_CYCLES + LINE_LIMIT)) begin
			@(negedge gbclk);
			cycles++;
			if (irq_vblank) begin
				kind = IRQ_VBLANK;
			end else if (irq_stat) begin
				kind = IRQ_STAT;
			end
		end
		if (kind == IRQ_NONE) begin
			errors++;
			$display("no interrupt pulse arrived within one frame");
		end
	endtask

	task automatic irq_test();
		logic [7:0] d;
		int         kind;
		int         stat_pulses;
		host_write(16'hff45, 8'd100);
		host_write(16'hff41, 8'h40);
		host_write(16'hff40, 8'h80);
		for (int f = 0; f < 2; f++) begin
			stat_pulses = 0;
			do begin
				wait_irq(kind);
				if (kind == IRQ_STAT) begin
					stat_pulses++;
					expect_read("irq_stat_ly", 16'hff44, 8'd100);
				end
			end while (kind == IRQ_STAT);
			check_count("irq_stat_per_frame", 1, stat_pulses);
			if (kind == IRQ_VBLANK) begin
				expect_read("irq_vblank_ly", 16'hff44, 8'd144);
				host_read(16'hff41, d);
				check_mode("irq_vblank_mode", mode_vblank, ppu_mode_e'(d[1:0]));
			end
		end
		host_write(16'hff40, 8'h00);
	endtask

	initial begin
		void'($urandom(32'hb7a6));
		rst_n     = 1'b0;
		host_req  = '0;
		pix_ready = 1'b0;
		repeat (4) @(negedge gbclk);
		rst_n     = 1'b1;
		pix_ready = 1'b1;
		register_test();
		memory_test();
		fill_vram();
		bg_test("bg_map0", 8'h80, 8'd37, 8'd13, 8'h1b, 1'b0);
		bg_test("bg_map1", 8'h88, 8'hff, 8'hfa, 8'he4, 1'b0);
		bg_test("bg_stall", 8'h80, 8'd37, 8'd13, 8'h1b, 1'b1);
		lock_test();
		irq_test();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sources.f */
+incdir+source
source/vid_pkg.sv
source/vid_memmap.sv
source/vid_ram.sv
source/vid_bus_arbiter.sv
source/vid_ppu.sv
source/vid_top.sv
verif/vid_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= vid_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_BIN   = ./$(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The run passes only if the testbench prints the pass line.
sim: build
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'STATUS: PASS'

clean:
	rm -rf $(OBJ_DIR)
